//--- src.f
+incdir+source
+incdir+sim
source/stq_pkg.sv
source/stq_alloc.sv
source/stq_fwd.sv
source/stq_drain.sv
source/stq_top.sv
sim/tb_stq.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_stq
RTL_TOP   ?= stq_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Isource source/stq_pkg.sv source/stq_alloc.sv \
	  source/stq_fwd.sv source/stq_drain.sv source/stq_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_stq_model.svh
`ifndef TB_STQ_MODEL_SVH
`define TB_STQ_MODEL_SVH

// Reference queue, oldest store at index 0
logic [`STQ_ADDR_W-1:0] q_addr [$];
stq_pkg::stq_size_e     q_size [$];
logic [`STQ_DATA_W-1:0] q_data [$];
bit                     q_cmt  [$];

logic [31:0] lfsr_state = 32'h4915;
int          err_cnt    = 0;
int          chk_cnt    = 0;

// Galois LFSR, one step per bit taken
function automatic logic [63:0] rand_bits(int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    r[i] = lfsr_state[0];
  end
  return r;
endfunction

function automatic stq_pkg::stq_strb_t ref_strb(stq_pkg::stq_size_e size,
                                                logic [`STQ_ADDR_W-1:0] addr);
  stq_pkg::stq_strb_t s;
  int nbytes;
  s = '0;
  nbytes = 1 << int'(size);
  for (int b = 0; b < nbytes; b++) begin
    s[int'(addr[`STQ_OFS_W-1:0]) + b] = 1'b1;
  end
  return s;
endfunction

// Byte of right-aligned store data that lands on a lane
function automatic logic [7:0] ref_lane(logic [`STQ_DATA_W-1:0] data,
                                        logic [`STQ_ADDR_W-1:0] addr, int lane);
  int sh;
  sh = lane - int'(addr[`STQ_OFS_W-1:0]);
  return data[sh*8 +: 8];
endfunction

function automatic bit same_dw(logic [`STQ_ADDR_W-1:0] a, logic [`STQ_ADDR_W-1:0] b);
  return a[`STQ_ADDR_W-1:`STQ_OFS_W] == b[`STQ_ADDR_W-1:`STQ_OFS_W];
endfunction

// Expected store buffer write, returns the number of stores it retires
function automatic int ref_drain(output logic [`STQ_ADDR_W-1:0] addr,
                                 output stq_pkg::stq_strb_t strb,
                                 output stq_pkg::stq_dword_u data);
  stq_pkg::stq_strb_t s1;
  int cnt;
  cnt  = 1;
  addr = {q_addr[0][`STQ_ADDR_W-1:`STQ_OFS_W], {`STQ_OFS_W{1'b0}}};
  strb = ref_strb(q_size[0], q_addr[0]);
  data = '0;
  for (int b = 0; b < `STQ_BYTES; b++) begin
    if (strb[b]) data.lanes[b] = ref_lane(q_data[0], q_addr[0], b);
  end
  if (q_addr.size() > 1 && q_cmt[1] && same_dw(q_addr[0], q_addr[1])) begin
    cnt = 2;
    s1  = ref_strb(q_size[1], q_addr[1]);
    for (int b = 0; b < `STQ_BYTES; b++) begin
      if (s1[b]) data.lanes[b] = ref_lane(q_data[1], q_addr[1], b);  // Younger wins
    end
    strb = strb | s1;
  end
  return cnt;
endfunction

// Youngest writer per byte, all queued stores are older than the load
function automatic void ref_fwd(input logic [`STQ_ADDR_W-1:0] ld_addr,
                                input stq_pkg::stq_size_e ld_size,
                                output stq_pkg::stq_strb_t strb,
                                output stq_pkg::stq_dword_u data);
  stq_pkg::stq_strb_t ld_s;
  stq_pkg::stq_strb_t es;
  ld_s = ref_strb(ld_size, ld_addr);
  strb = '0;
  data = '0;
  for (int i = 0; i < q_addr.size(); i++) begin
    es = ref_strb(q_size[i], q_addr[i]);
    for (int b = 0; b < `STQ_BYTES; b++) begin
      if (same_dw(q_addr[i], ld_addr) && es[b] && ld_s[b]) begin
        strb[b]       = 1'b1;
        data.lanes[b] = ref_lane(q_data[i], q_addr[i], b);
      end
    end
  end
endfunction

function automatic bit lanes_differ(stq_pkg::stq_strb_t strb, stq_pkg::stq_dword_u a,
                                    stq_pkg::stq_dword_u b);
  bit d;
  d = 1'b0;
  for (int i = 0; i < `STQ_BYTES; i++) begin
    if (strb[i] && a.lanes[i] !== b.lanes[i]) d = 1'b1;
  end
  return d;
endfunction

task automatic compare_sb(logic [`STQ_ADDR_W-1:0] e_addr, logic [`STQ_ADDR_W-1:0] g_addr,
                          stq_pkg::stq_strb_t e_strb, stq_pkg::stq_strb_t g_strb,
                          stq_pkg::stq_dword_u e_data, stq_pkg::stq_dword_u g_data);
  chk_cnt++;
  if (e_addr !== g_addr || e_strb !== g_strb || lanes_differ(e_strb, e_data, g_data)) begin
    err_cnt++;
    $display("** Error at %0t: store buffer write, addr %h exp %h, strb %b exp %b, data %h exp %h",
             $time, g_addr, e_addr, g_strb, e_strb, g_data.dw, e_data.dw);
  end
endtask

task automatic compare_fwd(stq_pkg::stq_strb_t e_strb, stq_pkg::stq_strb_t g_strb,
                           stq_pkg::stq_dword_u e_data, stq_pkg::stq_dword_u g_data);
  chk_cnt++;
  if (e_strb !== g_strb || lanes_differ(e_strb, e_data, g_data)) begin
    err_cnt++;
    $display("** Error at %0t: forward result, strb %b exp %b, data %h exp %h",
             $time, g_strb, e_strb, g_data.dw, e_data.dw);
  end
endtask

`endif

//--- sim/tb_stq.sv
`timescale 1ns/100ps
`include "stq_config.svh"

module tb_stq;

  localparam int RAND_CYCLES = 200;
  localparam int STORE_TOTAL = 4 + 4 + 4 + 8 + RAND_CYCLES;
  localparam int CYCLE_LIMIT = STORE_TOTAL * 20 + 200;

  logic                   clk;
  logic                   reset_n;
  logic                   st_valid;
  logic [`STQ_ADDR_W-1:0] st_addr;
  stq_pkg::stq_size_e     st_size;
  logic [`STQ_DATA_W-1:0] st_data;
  logic                   st_ready;
  logic                   commit;
  logic                   ld_valid;
  logic [`STQ_ADDR_W-1:0] ld_addr;
  stq_pkg::stq_size_e     ld_size;
  logic                   fwd_valid;
  stq_pkg::stq_strb_t     fwd_strb;
  stq_pkg::stq_dword_u    fwd_data;
  logic                   sb_valid;
  logic [`STQ_ADDR_W-1:0] sb_addr;
  stq_pkg::stq_strb_t     sb_strb;
  stq_pkg::stq_dword_u    sb_data;
  logic                   sb_ready;

  bit                     fwd_pend;
  stq_pkg::stq_strb_t     fwd_exp_strb;
  stq_pkg::stq_dword_u    fwd_exp_data;
  int                     cycles;

  `include "tb_stq_model.svh"

  stq_top dut0 (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_st_valid(st_valid), .i_st_addr(st_addr), .i_st_size(st_size),
    .i_st_data(st_data), .o_st_ready(st_ready), .i_commit(commit),
    .i_ld_valid(ld_valid), .i_ld_addr(ld_addr), .i_ld_size(ld_size),
    .o_fwd_valid(fwd_valid), .o_fwd_strb(fwd_strb), .o_fwd_data(fwd_data),
    .o_sb_valid(sb_valid), .o_sb_addr(sb_addr), .o_sb_strb(sb_strb),
    .o_sb_data(sb_data), .i_sb_ready(sb_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  // ==========================================================================
  // Compare process, pre-edge values at each rising edge
  // ==========================================================================
  always @(posedge clk) begin
    logic [`STQ_ADDR_W-1:0] e_addr;
    stq_pkg::stq_strb_t     e_strb;
    stq_pkg::stq_dword_u    e_data;
    int                     n;
    if (reset_n) begin
      if (fwd_pend && !fwd_valid) begin
        err_cnt++;
        $display("No forward result one cycle after a load query at %0t", $time);
      end else if (fwd_pend) begin
        compare_fwd(fwd_exp_strb, fwd_strb, fwd_exp_data, fwd_data);
      end else if (fwd_valid) begin
        err_cnt++;
        $display("Forward result without a load query at %0t", $time);
      end
      fwd_pend = ld_valid;
      if (ld_valid) ref_fwd(ld_addr, ld_size, fwd_exp_strb, fwd_exp_data);
      if (sb_valid && sb_ready) begin
        if (q_addr.size() == 0 || !q_cmt[0]) begin
          err_cnt++;
          $display("Store buffer write with no committed store queued at %0t", $time);
        end else begin
          n = ref_drain(e_addr, e_strb, e_data);
          compare_sb(e_addr, sb_addr, e_strb, sb_strb, e_data, sb_data);
          repeat (n) begin
            void'(q_addr.pop_front());
            void'(q_size.pop_front());
            void'(q_data.pop_front());
            void'(q_cmt.pop_front());
          end
        end
      end else if (q_addr.size() != 0 && q_cmt[0] && !sb_valid) begin
        err_cnt++;
        $display("Committed head store not requested at %0t", $time);
      end
      if (st_valid && st_ready) begin
        q_addr.push_back(st_addr);
        q_size.push_back(st_size);
        q_data.push_back(st_data);
        q_cmt.push_back(1'b0);
      end
      if (commit) begin
        for (int i = 0; i < q_cmt.size(); i++) begin
          if (!q_cmt[i]) begin
            q_cmt[i] = 1'b1;
            break;
          end
        end
      end
    end
  end

  function automatic bit has_uncommitted();
    foreach (q_cmt[i]) begin
      if (!q_cmt[i]) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic store_push(logic [`STQ_ADDR_W-1:0] a, stq_pkg::stq_size_e s,
                            logic [`STQ_DATA_W-1:0] d);
    @(negedge clk);
    st_valid = 1'b1;
    st_addr  = a;
    st_size  = s;
    st_data  = d;
    while (!st_ready) @(negedge clk);
    @(negedge clk);
    st_valid = 1'b0;
  endtask

  task automatic commit_one();
    @(negedge clk);
    commit = 1'b1;
    @(negedge clk);
    commit = 1'b0;
  endtask

  task automatic commit_all();
    while (has_uncommitted()) commit_one();
  endtask

  task automatic drive_sb_ready(logic v);
    @(negedge clk);
    sb_ready = v;
  endtask

  task automatic wait_drained();
    while (q_addr.size() != 0) @(negedge clk);
  endtask

  task automatic load_query(logic [`STQ_ADDR_W-1:0] a, stq_pkg::stq_size_e s);
    @(negedge clk);
    ld_valid = 1'b1;
    ld_addr  = a;
    ld_size  = s;
    @(negedge clk);
    ld_valid = 1'b0;
    @(negedge clk);
  endtask

  task automatic test_done(string name, int errs_before);
    $display("%s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  function automatic logic [`STQ_ADDR_W-1:0] rand_addr(stq_pkg::stq_size_e s);
    logic [`STQ_OFS_W-1:0] ofs;
    logic                  dw;
    dw  = rand_bits(1) != 0;
    ofs = `STQ_OFS_W'(rand_bits(3));
    ofs = ofs & ~`STQ_OFS_W'((1 << int'(s)) - 1);  // Keep it size aligned
    return 32'h4000 + (dw ? 32'd8 : 32'd0) + `STQ_ADDR_W'(ofs);
  endfunction

  initial begin
    int e0;
    reset_n  = 1'b0;
    st_valid = 1'b0;
    st_addr  = '0;
    st_size  = stq_pkg::SIZE_B;
    st_data  = '0;
    commit   = 1'b0;
    ld_valid = 1'b0;
    ld_addr  = '0;
    ld_size  = stq_pkg::SIZE_B;
    sb_ready = 1'b1;
    fwd_pend = 1'b0;
    cycles   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    e0 = err_cnt;
    store_push(32'h1005, stq_pkg::SIZE_B, 64'h11);
    commit_one();
    wait_drained();
    store_push(32'h1006, stq_pkg::SIZE_H, 64'h2233);
    commit_one();
    wait_drained();
    store_push(32'h1004, stq_pkg::SIZE_W, 64'h44556677);
    commit_one();
    wait_drained();
    store_push(32'h1000, stq_pkg::SIZE_D, 64'h8899aabbccddeeff);
    commit_one();
    wait_drained();
    test_done("Single stores", e0);

    // Overlapping pair merges while the store buffer stalls
    e0 = err_cnt;
    drive_sb_ready(1'b0);
    store_push(32'h1000, stq_pkg::SIZE_W, 64'ha1a2a3a4);
    store_push(32'h1002, stq_pkg::SIZE_H, 64'hb1b2);
    commit_all();
    drive_sb_ready(1'b1);
    wait_drained();
    // Both committed before the drain sees them, still two writes
    drive_sb_ready(1'b0);
    store_push(32'h1008, stq_pkg::SIZE_B, 64'hc1);
    store_push(32'h1010, stq_pkg::SIZE_B, 64'hd1);
    commit_all();
    drive_sb_ready(1'b1);
    wait_drained();
    test_done("Merge and split", e0);

    e0 = err_cnt;
    drive_sb_ready(1'b0);
    store_push(32'h2000, stq_pkg::SIZE_D, 64'h0102030405060708);
    store_push(32'h2004, stq_pkg::SIZE_W, 64'h11121314);
    store_push(32'h2005, stq_pkg::SIZE_B, 64'h21);
    store_push(32'h2002, stq_pkg::SIZE_H, 64'h3132);
    load_query(32'h2000, stq_pkg::SIZE_D);
    load_query(32'h2004, stq_pkg::SIZE_W);
    load_query(32'h3000, stq_pkg::SIZE_D);
    commit_all();
    drive_sb_ready(1'b1);
    wait_drained();
    test_done("Forwarding", e0);

    e0 = err_cnt;
    drive_sb_ready(1'b0);
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      store_push(32'h3000 + 32'(i * 8), stq_pkg::SIZE_D, 64'h5a00 + 64'(i));
    end
    if (st_ready) begin
      err_cnt++;
      $display("o_st_ready stayed high with every entry filled");
    end
    commit_all();
    drive_sb_ready(1'b1);
    wait_drained();
    test_done("Full queue", e0);

    e0 = err_cnt;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      @(negedge clk);
      st_valid = rand_bits(1) != 0;
      st_size  = stq_pkg::stq_size_e'(rand_bits(2));
      st_addr  = rand_addr(st_size);
      st_data  = rand_bits(64);
      commit   = (rand_bits(1) != 0) && has_uncommitted();
      sb_ready = rand_bits(1) != 0;
      ld_valid = rand_bits(1) != 0;
      ld_size  = stq_pkg::stq_size_e'(rand_bits(2));
      ld_addr  = rand_addr(ld_size);
    end
    @(negedge clk);
    st_valid = 1'b0;
    commit   = 1'b0;
    ld_valid = 1'b0;
    sb_ready = 1'b1;
    commit_all();
    wait_drained();
    repeat (2) @(negedge clk);
    test_done("Random mix", e0);

    $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- source/stq_top.sv
`timescale 1ns/100ps
`include "stq_config.svh"

module stq_top (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // Store input
  input  logic                   i_st_valid,
  input  logic [`STQ_ADDR_W-1:0] i_st_addr,
  input  stq_pkg::stq_size_e     i_st_size,
  input  logic [`STQ_DATA_W-1:0] i_st_data,
  output logic                   o_st_ready,

  input  logic                   i_commit,

  // Load forwarding query
  input  logic                   i_ld_valid,
  input  logic [`STQ_ADDR_W-1:0] i_ld_addr,
  input  stq_pkg::stq_size_e     i_ld_size,
  output logic                   o_fwd_valid,
  output stq_pkg::stq_strb_t     o_fwd_strb,
  output stq_pkg::stq_dword_u    o_fwd_data,

  // Store buffer
  output logic                   o_sb_valid,
  output logic [`STQ_ADDR_W-1:0] o_sb_addr,
  output stq_pkg::stq_strb_t     o_sb_strb,
  output stq_pkg::stq_dword_u    o_sb_data,
  input  logic                   i_sb_ready
);

  stq_pkg::stq_ptr_oh_t   w_ent_valid;
  stq_pkg::stq_ptr_oh_t   w_ent_cmt;
  logic [`STQ_ADDR_W-1:0] w_ent_addr [`STQ_DEPTH];
  stq_pkg::stq_size_e     w_ent_size [`STQ_DEPTH];
  logic [`STQ_DATA_W-1:0] w_ent_data [`STQ_DEPTH];
  stq_pkg::stq_ptr_oh_t   w_out_ptr_oh;
  logic [1:0]             w_pop_cnt;

  stq_alloc u_alloc (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_st_valid   (i_st_valid),
    .i_st_addr    (i_st_addr),
    .i_st_size    (i_st_size),
    .i_st_data    (i_st_data),
    .o_st_ready   (o_st_ready),
    .i_commit     (i_commit),
    .i_pop_cnt    (w_pop_cnt),
    .o_ent_valid  (w_ent_valid),
    .o_ent_cmt    (w_ent_cmt),
    .o_ent_addr   (w_ent_addr),
    .o_ent_size   (w_ent_size),
    .o_ent_data   (w_ent_data),
    .o_out_ptr_oh (w_out_ptr_oh)
  );

  stq_fwd u_fwd (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ld_valid   (i_ld_valid),
    .i_ld_addr    (i_ld_addr),
    .i_ld_size    (i_ld_size),
    .i_ent_valid  (w_ent_valid),
    .i_ent_addr   (w_ent_addr),
    .i_ent_size   (w_ent_size),
    .i_ent_data   (w_ent_data),
    .i_out_ptr_oh (w_out_ptr_oh),
    .o_fwd_valid  (o_fwd_valid),
    .o_fwd_strb   (o_fwd_strb),
    .o_fwd_data   (o_fwd_data)
  );

  stq_drain u_drain (
    .i_ent_valid  (w_ent_valid),
    .i_ent_cmt    (w_ent_cmt),
    .i_ent_addr   (w_ent_addr),
    .i_ent_size   (w_ent_size),
    .i_ent_data   (w_ent_data),
    .i_out_ptr_oh (w_out_ptr_oh),
    .o_sb_valid   (o_sb_valid),
    .o_sb_addr    (o_sb_addr),
    .o_sb_strb    (o_sb_strb),
    .o_sb_data    (o_sb_data),
    .i_sb_ready   (i_sb_ready),
    .o_pop_cnt    (w_pop_cnt)
  );

endmodule

//--- source/stq_drain.sv
`timescale 1ns/100ps
`include "stq_config.svh"

module stq_drain (
  // Queue contents
  input  stq_pkg::stq_ptr_oh_t   i_ent_valid,
  input  stq_pkg::stq_ptr_oh_t   i_ent_cmt,
  input  logic [`STQ_ADDR_W-1:0] i_ent_addr [`STQ_DEPTH],
  input  stq_pkg::stq_size_e     i_ent_size [`STQ_DEPTH],
  input  logic [`STQ_DATA_W-1:0] i_ent_data [`STQ_DEPTH],
  input  stq_pkg::stq_ptr_oh_t   i_out_ptr_oh,

  // Store buffer request
  output logic                   o_sb_valid,
  output logic [`STQ_ADDR_W-1:0] o_sb_addr,
  output stq_pkg::stq_strb_t     o_sb_strb,
  output stq_pkg::stq_dword_u    o_sb_data,
  input  logic                   i_sb_ready,

  output logic [1:0]             o_pop_cnt
);

  stq_pkg::stq_idx_t   w_head_idx;
  stq_pkg::stq_idx_t   w_next_idx;
  logic                w_head_rdy;
  logic                w_next_rdy;
  logic                w_same_dw;
  logic                w_merge;
  stq_pkg::stq_strb_t  w_head_strb;
  stq_pkg::stq_strb_t  w_next_strb;
  stq_pkg::stq_dword_u w_head_data;
  stq_pkg::stq_dword_u w_next_data;

  // ==========================================================================
  // Head and next-oldest entries
  // ==========================================================================
  assign w_head_idx = stq_pkg::oh_to_idx(i_out_ptr_oh);
  assign w_next_idx = w_head_idx + stq_pkg::stq_idx_t'(1);

  assign w_head_rdy = i_ent_valid[w_head_idx] & i_ent_cmt[w_head_idx];
  assign w_next_rdy = i_ent_valid[w_next_idx] & i_ent_cmt[w_next_idx];

  assign w_head_strb = stq_pkg::size_strb(i_ent_size[w_head_idx],
                                          i_ent_addr[w_head_idx][`STQ_OFS_W-1:0]);
  assign w_next_strb = stq_pkg::size_strb(i_ent_size[w_next_idx],
                                          i_ent_addr[w_next_idx][`STQ_OFS_W-1:0]);

  assign w_head_data.dw = i_ent_data[w_head_idx] <<
                          {i_ent_addr[w_head_idx][`STQ_OFS_W-1:0], 3'b000};
  assign w_next_data.dw = i_ent_data[w_next_idx] <<
                          {i_ent_addr[w_next_idx][`STQ_OFS_W-1:0], 3'b000};

  assign w_same_dw = i_ent_addr[w_head_idx][`STQ_ADDR_W-1:`STQ_OFS_W] ==
                     i_ent_addr[w_next_idx][`STQ_ADDR_W-1:`STQ_OFS_W];

  // Pair only when both are committed and share a doubleword
  assign w_merge = w_head_rdy & w_next_rdy & w_same_dw;

  // ==========================================================================
  // Request toward the store buffer
  // ==========================================================================
  assign o_sb_valid = w_head_rdy;
  assign o_sb_addr  = {i_ent_addr[w_head_idx][`STQ_ADDR_W-1:`STQ_OFS_W], {`STQ_OFS_W{1'b0}}};
  assign o_sb_strb  = w_merge ? (w_head_strb | w_next_strb) : w_head_strb;

  always_comb begin
    o_sb_data = w_head_data;
    for (int b = 0; b < `STQ_BYTES; b++) begin
      if (w_merge && w_next_strb[b]) begin
        o_sb_data.lanes[b] = w_next_data.lanes[b];  // Younger store wins
      end
    end
  end

  always_comb begin
    if (o_sb_valid && i_sb_ready) begin
      o_pop_cnt = w_merge ? 2'd2 : 2'd1;
    end else begin
      o_pop_cnt = 2'd0;
    end
  end

  // Every request carries at least one byte
  always_comb begin
    if (o_sb_valid) begin
      a_strb_nonzero: assert (o_sb_strb != '0)
        else $error("store buffer request with empty strobe");
    end
  end

endmodule

//--- source/stq_fwd.sv
`timescale 1ns/100ps
`include "stq_config.svh"

module stq_fwd (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // Load query
  input  logic                   i_ld_valid,
  input  logic [`STQ_ADDR_W-1:0] i_ld_addr,
  input  stq_pkg::stq_size_e     i_ld_size,

  // Queue contents
  input  stq_pkg::stq_ptr_oh_t   i_ent_valid,
  input  logic [`STQ_ADDR_W-1:0] i_ent_addr [`STQ_DEPTH],
  input  stq_pkg::stq_size_e     i_ent_size [`STQ_DEPTH],
  input  logic [`STQ_DATA_W-1:0] i_ent_data [`STQ_DEPTH],
  input  stq_pkg::stq_ptr_oh_t   i_out_ptr_oh,

  // Answer, one cycle after the query
  output logic                   o_fwd_valid,
  output stq_pkg::stq_strb_t     o_fwd_strb,
  output stq_pkg::stq_dword_u    o_fwd_data
);

  stq_pkg::stq_strb_t  w_ld_strb;
  stq_pkg::stq_idx_t   w_out_idx;
  stq_pkg::stq_strb_t  w_hit_strb [`STQ_DEPTH];
  stq_pkg::stq_dword_u w_aligned  [`STQ_DEPTH];
  stq_pkg::stq_strb_t  w_fwd_strb;
  stq_pkg::stq_dword_u w_fwd_data;

  assign w_ld_strb = stq_pkg::size_strb(i_ld_size, i_ld_addr[`STQ_OFS_W-1:0]);
  assign w_out_idx = stq_pkg::oh_to_idx(i_out_ptr_oh);

  // ==========================================================================
  // Per-entry byte overlap with the load
  // ==========================================================================
  for (genvar s = 0; s < `STQ_DEPTH; s++) begin : g_ent
    logic               w_same_dw;
    stq_pkg::stq_strb_t w_ent_strb;

    assign w_same_dw  = i_ent_addr[s][`STQ_ADDR_W-1:`STQ_OFS_W] ==
                        i_ld_addr[`STQ_ADDR_W-1:`STQ_OFS_W];
    assign w_ent_strb = stq_pkg::size_strb(i_ent_size[s], i_ent_addr[s][`STQ_OFS_W-1:0]);

    assign w_hit_strb[s]   = (i_ent_valid[s] && w_same_dw) ? (w_ent_strb & w_ld_strb) : '0;
    assign w_aligned[s].dw = i_ent_data[s] << {i_ent_addr[s][`STQ_OFS_W-1:0], 3'b000};
  end

  // ==========================================================================
  // Youngest writer per lane
  // ==========================================================================
  always_comb begin
    stq_pkg::stq_idx_t idx;
    w_fwd_strb = '0;
    w_fwd_data = '0;
    for (int b = 0; b < `STQ_BYTES; b++) begin
      // Walk oldest to youngest, later hits overwrite
      for (int k = 0; k < `STQ_DEPTH; k++) begin
        idx = w_out_idx + stq_pkg::stq_idx_t'(k);
        if (w_hit_strb[idx][b]) begin
          w_fwd_strb[b]       = 1'b1;
          w_fwd_data.lanes[b] = w_aligned[idx].lanes[b];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_fwd_valid <= 1'b0;
    end else begin
      o_fwd_valid <= i_ld_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ld_valid) begin
      o_fwd_strb <= w_fwd_strb;
      o_fwd_data <= w_fwd_data;
    end
  end

  // Forwarded bytes stay inside what the load asked for
  a_strb_in_load: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_fwd_valid |-> ((o_fwd_strb & ~$past(w_ld_strb)) == '0))
    else $error("forward strobe outside load bytes");

endmodule

//--- source/stq_alloc.sv
`timescale 1ns/100ps
`include "stq_config.svh"

module stq_alloc (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  // Store input
  input  logic                   i_st_valid,
  input  logic [`STQ_ADDR_W-1:0] i_st_addr,
  input  stq_pkg::stq_size_e     i_st_size,
  input  logic [`STQ_DATA_W-1:0] i_st_data,
  output logic                   o_st_ready,

  input  logic                   i_commit,
  input  logic [1:0]             i_pop_cnt,    // From drain, 0..2

  // Entry state toward lookup and drain
  output stq_pkg::stq_ptr_oh_t   o_ent_valid,
  output stq_pkg::stq_ptr_oh_t   o_ent_cmt,
  output logic [`STQ_ADDR_W-1:0] o_ent_addr [`STQ_DEPTH],
  output stq_pkg::stq_size_e     o_ent_size [`STQ_DEPTH],
  output logic [`STQ_DATA_W-1:0] o_ent_data [`STQ_DEPTH],
  output stq_pkg::stq_ptr_oh_t   o_out_ptr_oh
);

  stq_pkg::stq_idx_t      r_in_ptr;
  stq_pkg::stq_idx_t      r_cmt_ptr;
  stq_pkg::stq_idx_t      r_out_ptr;
  stq_pkg::stq_idx_t      w_out_ptr_nxt;
  stq_pkg::stq_ptr_oh_t   r_ent_valid;
  stq_pkg::stq_ptr_oh_t   r_ent_cmt;
  stq_pkg::stq_ptr_oh_t   w_in_oh;
  stq_pkg::stq_ptr_oh_t   w_cmt_oh;
  stq_pkg::stq_ptr_oh_t   w_pop_oh;
  logic                   w_accept;
  logic [`STQ_OFS_W-1:0]  w_align_mask;

  logic [`STQ_ADDR_W-1:0] r_ent_addr [`STQ_DEPTH];
  stq_pkg::stq_size_e     r_ent_size [`STQ_DEPTH];
  logic [`STQ_DATA_W-1:0] r_ent_data [`STQ_DEPTH];

  assign o_st_ready = ~&r_ent_valid;  // Full when every slot holds a store
  assign w_accept   = i_st_valid & o_st_ready;

  assign w_in_oh      = stq_pkg::stq_ptr_oh_t'(1) << r_in_ptr;
  assign w_cmt_oh     = stq_pkg::stq_ptr_oh_t'(1) << r_cmt_ptr;
  assign o_out_ptr_oh = stq_pkg::stq_ptr_oh_t'(1) << r_out_ptr;

  // Slots freed by drain this cycle
  assign w_out_ptr_nxt = r_out_ptr + stq_pkg::stq_idx_t'(1);
  always_comb begin
    w_pop_oh = '0;
    if (i_pop_cnt != 2'd0) begin
      w_pop_oh[r_out_ptr] = 1'b1;
    end
    if (i_pop_cnt == 2'd2) begin
      w_pop_oh[w_out_ptr_nxt] = 1'b1;
    end
  end

  // ==========================================================================
  // Pointers and entry flags
  // ==========================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr    <= '0;
      r_cmt_ptr   <= '0;
      r_out_ptr   <= '0;
      r_ent_valid <= '0;
      r_ent_cmt   <= '0;
    end else begin
      if (w_accept) begin
        r_in_ptr <= r_in_ptr + stq_pkg::stq_idx_t'(1);
      end
      if (i_commit) begin
        r_cmt_ptr <= r_cmt_ptr + stq_pkg::stq_idx_t'(1);
      end
      r_out_ptr   <= r_out_ptr + stq_pkg::stq_idx_t'(i_pop_cnt);
      r_ent_valid <= (r_ent_valid & ~w_pop_oh) | (w_accept ? w_in_oh : '0);
      r_ent_cmt   <= (r_ent_cmt & ~w_pop_oh) | (i_commit ? w_cmt_oh : '0);
    end
  end

  // Store payload
  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_ent_addr[r_in_ptr] <= i_st_addr;
      r_ent_size[r_in_ptr] <= i_st_size;
      r_ent_data[r_in_ptr] <= i_st_data;
    end
  end

  assign o_ent_valid = r_ent_valid;
  assign o_ent_cmt   = r_ent_cmt;
  assign o_ent_addr  = r_ent_addr;
  assign o_ent_size  = r_ent_size;
  assign o_ent_data  = r_ent_data;

  // ==========================================================================
  // Checks
  // ==========================================================================
  assign w_align_mask = `STQ_OFS_W'((1 << i_st_size) - 1);

  // In pointer must always land on a free slot
  a_accept_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_accept |-> !r_ent_valid[r_in_ptr])
    else $error("store accepted into a busy entry");

  a_commit_live: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit |-> (r_ent_valid[r_cmt_ptr] && !r_ent_cmt[r_cmt_ptr]))
    else $error("commit without an uncommitted store");

  a_addr_align: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_accept |-> ((i_st_addr[`STQ_OFS_W-1:0] & w_align_mask) == '0))
    else $error("misaligned store address");

endmodule

//--- source/stq_pkg.sv
`include "stq_config.svh"

package stq_pkg;

  // Access size, byte count is 1 << size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } stq_size_e;

  typedef logic [7:0]            stq_byte_t;
  typedef logic [`STQ_BYTES-1:0] stq_strb_t;
  typedef logic [`STQ_DEPTH-1:0] stq_ptr_oh_t;
  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  // One doubleword, whole or lane by lane
  typedef union packed {
    logic [`STQ_DATA_W-1:0]     dw;
    stq_byte_t [`STQ_BYTES-1:0] lanes;
  } stq_dword_u;

  // Byte enables of an access inside its doubleword
  function automatic stq_strb_t size_strb(stq_size_e size, logic [`STQ_OFS_W-1:0] ofs);
    stq_strb_t base;
    case (size)
      SIZE_B:  base = stq_strb_t'(1);
      SIZE_H:  base = stq_strb_t'(3);
      SIZE_W:  base = stq_strb_t'(15);
      default: base = '1;
    endcase
    return base << ofs;
  endfunction

  function automatic stq_idx_t oh_to_idx(stq_ptr_oh_t oh);
    stq_idx_t idx;
    idx = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (oh[i]) begin
        idx = idx | stq_idx_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

//--- source/stq_config.svh
`ifndef STQ_CONFIG_SVH
`define STQ_CONFIG_SVH

// Queue geometry
`define STQ_DEPTH  8
`define STQ_IDX_W  3   // log2 of depth

// Datapath
`define STQ_ADDR_W 32
`define STQ_DATA_W 64
`define STQ_BYTES  8   // Lanes per doubleword
`define STQ_OFS_W  3   // Byte offset inside a doubleword

`endif
